/* common/mips_isa_pkg.sv */
package mips_isa_pkg;

	localparam int WORD_W     = 32;
	localparam int REG_ADDR_W = 5;
	localparam int OPCODE_W   = 6;
	localparam int FUNCT_W    = 6;
	localparam int IMM_W      = 16;
	localparam int SHAMT_W    = 5;

	typedef logic [WORD_W-1:0]     word_t;
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;

	// primary opcodes, bits 31:26
	typedef enum logic [OPCODE_W-1:0] {
		OP_SPECIAL = 6'h00,
		OP_ADDIU   = 6'h09,
		OP_ORI     = 6'h0d,
		OP_LUI     = 6'h0f,
		OP_LW      = 6'h23,
		OP_SW      = 6'h2b
	} opcode_e;

	// funct field of SPECIAL, bits 5:0
	typedef enum logic [FUNCT_W-1:0] {
		FN_SLL  = 6'h00,
		FN_ADDU = 6'h21,
		FN_SUBU = 6'h23,
		FN_AND  = 6'h24,
		FN_OR   = 6'h25,
		FN_XOR  = 6'h26,
		FN_SLT  = 6'h2a,
		FN_SLTU = 6'h2b
	} funct_e;

	// sll $0,$0,0
	localparam word_t NOP_WORD = '0;

endpackage

/* common/pipe_pkg.sv */
package pipe_pkg;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_SLTU,
		ALU_SLL,
		ALU_LUI
	} alu_op_e;

	// second alu operand
	typedef enum logic {
		OPB_REG,
		OPB_IMM
	} opb_src_e;

	// where an execute operand is taken from
	typedef enum logic [1:0] {
		FWD_REG,
		FWD_MEM,
		FWD_WB
	} fwd_src_e;

	typedef enum logic {
		WB_ALU,
		WB_LOAD
	} wb_src_e;

endpackage

/* fetch/fetch_stage.sv */
module fetch_stage
	import mips_isa_pkg::*;
#(
	parameter word_t RESET_PC = 32'hbfc00000
) (
	input  logic  clk,
	input  logic  rst_n,
	input  logic  stall,
	output word_t fetch_addr,
	output logic  fetch_en,
	input  word_t inst_rdata,
	output word_t id_pc,
	output word_t id_inst
);
	word_t pc;
	logic  id_valid;

	// pc is the address sent last cycle, so it pairs with inst_rdata now
	// until id_valid is set nothing has been requested and pc itself goes out
	assign fetch_addr = (stall || !id_valid) ? pc : pc + 32'd4;
	assign fetch_en   = rst_n;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc       <= RESET_PC;
			id_valid <= 1'b0;
		end else begin
			pc       <= fetch_addr;
			id_valid <= 1'b1;
		end
	end

	// sram output register holds the instruction half of the decode register
	assign id_pc   = pc;
	assign id_inst = id_valid ? inst_rdata : NOP_WORD;

endmodule

/* decode/reg_file.sv */
module reg_file
	import mips_isa_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  reg_addr_t raddr1,
	input  reg_addr_t raddr2,
	output word_t     rdata1,
	output word_t     rdata2,
	input  logic      we,
	input  reg_addr_t waddr,
	input  word_t     wdata
);
	word_t regs [1:31];

	always_ff @(posedge clk) begin
		if (rst_n && we && waddr != '0)
			regs[waddr] <= wdata;
	end

	// same-cycle write passes straight to the read side
	assign rdata1 = (raddr1 == '0) ? '0 :
		(we && waddr == raddr1) ? wdata : regs[raddr1];
	assign rdata2 = (raddr2 == '0) ? '0 :
		(we && waddr == raddr2) ? wdata : regs[raddr2];

endmodule

/* decode/decode_stage.sv */
module decode_stage
	import mips_isa_pkg::*;
	import pipe_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  word_t     id_inst,
	input  word_t     id_pc,
	input  word_t     rs_data,
	input  word_t     rt_data,
	input  reg_addr_t ex_rw,
	input  logic      ex_load,
	output reg_addr_t rs_addr,
	output reg_addr_t rt_addr,
	output logic      stall,
	output alu_op_e   d_alu_op,
	output opb_src_e  d_opb_src,
	output word_t     d_imm,
	output reg_addr_t d_rs,
	output reg_addr_t d_rt,
	output reg_addr_t d_rw,
	output logic      d_reg_we,
	output logic      d_load,
	output logic      d_store,
	output word_t     d_pc,
	output word_t     d_rs_val,
	output word_t     d_rt_val
);
	opcode_e            opcode;
	funct_e             funct;
	reg_addr_t          rs_f, rt_f, rd_f;
	logic [IMM_W-1:0]   imm16;
	logic [SHAMT_W-1:0] shamt;
	word_t              sign_imm, zero_imm, shamt_imm;
	logic               we_raw, load, store, uses_rs, uses_rt, rs_is_rt;

	assign opcode = opcode_e'(id_inst[31:26]);
	assign funct  = funct_e'(id_inst[5:0]);
	assign rs_f   = id_inst[25:21];
	assign rt_f   = id_inst[20:16];
	assign rd_f   = id_inst[15:11];
	assign shamt  = id_inst[10:6];
	assign imm16  = id_inst[IMM_W-1:0];

	assign sign_imm  = {{(WORD_W-IMM_W){imm16[IMM_W-1]}}, imm16};
	assign zero_imm  = {{(WORD_W-IMM_W){1'b0}}, imm16};
	assign shamt_imm = {{(WORD_W-SHAMT_W){1'b0}}, shamt};

	always_comb begin
		d_alu_op  = ALU_ADD;
		d_opb_src = OPB_IMM;
		d_imm     = sign_imm;
		d_rw      = rt_f;
		we_raw    = 1'b0;
		load      = 1'b0;
		store     = 1'b0;
		uses_rs   = 1'b1;
		uses_rt   = 1'b0;
		rs_is_rt  = 1'b0;
		case (opcode)
			OP_SPECIAL: begin
				d_opb_src = OPB_REG;
				d_rw      = rd_f;
				we_raw    = 1'b1;
				uses_rt   = 1'b1;
				case (funct)
					FN_ADDU: d_alu_op = ALU_ADD;
					FN_SUBU: d_alu_op = ALU_SUB;
					FN_AND:  d_alu_op = ALU_AND;
					FN_OR:   d_alu_op = ALU_OR;
					FN_XOR:  d_alu_op = ALU_XOR;
					FN_SLT:  d_alu_op = ALU_SLT;
					FN_SLTU: d_alu_op = ALU_SLTU;
					FN_SLL: begin
						// rt goes out on the first read port with the shift amount as immediate
						d_alu_op  = ALU_SLL;
						d_opb_src = OPB_IMM;
						d_imm     = shamt_imm;
						rs_is_rt  = 1'b1;
						uses_rt   = 1'b0;
					end
					default: begin
						we_raw  = 1'b0;
						uses_rs = 1'b0;
						uses_rt = 1'b0;
					end
				endcase
			end
			OP_ADDIU: we_raw = 1'b1;
			OP_ORI: begin
				d_alu_op = ALU_OR;
				d_imm    = zero_imm;
				we_raw   = 1'b1;
			end
			OP_LUI: begin
				d_alu_op = ALU_LUI;
				d_imm    = zero_imm;
				we_raw   = 1'b1;
				uses_rs  = 1'b0;
			end
			OP_LW: begin
				we_raw = 1'b1;
				load   = 1'b1;
			end
			OP_SW: begin
				store   = 1'b1;
				uses_rt = 1'b1;
			end
			default: uses_rs = 1'b0;
		endcase
	end

	assign rs_addr = rs_is_rt ? rt_f : rs_f;
	assign rt_addr = rt_f;

	assign stall = ex_load && (ex_rw != '0) &&
		((uses_rs && rs_addr == ex_rw) || (uses_rt && rt_addr == ex_rw));

	// stalled or r0 targets leave as a bubble
	assign d_reg_we = we_raw && (d_rw != '0) && !stall;
	assign d_load   = load && !stall;
	assign d_store  = store && !stall;

	assign d_rs     = rs_addr;
	assign d_rt     = rt_addr;
	assign d_pc     = id_pc;
	assign d_rs_val = rs_data;
	assign d_rt_val = rt_data;

endmodule

/* execute/execute_stage.sv */
module execute_stage
	import mips_isa_pkg::*;
	import pipe_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  alu_op_e   d_alu_op,
	input  opb_src_e  d_opb_src,
	input  word_t     d_imm,
	input  reg_addr_t d_rs,
	input  reg_addr_t d_rt,
	input  reg_addr_t d_rw,
	input  logic      d_reg_we,
	input  logic      d_load,
	input  logic      d_store,
	input  word_t     d_pc,
	input  word_t     d_rs_val,
	input  word_t     d_rt_val,
	input  reg_addr_t mem_rw,
	input  logic      mem_we,
	input  word_t     mem_result,
	input  reg_addr_t wb_rw,
	input  logic      wb_we,
	input  word_t     wb_data,
	output reg_addr_t ex_rw,
	output logic      ex_load,
	output word_t     m_result,
	output word_t     m_store_data,
	output reg_addr_t m_rw,
	output logic      m_reg_we,
	output logic      m_load,
	output logic      m_store,
	output word_t     m_pc
);
	alu_op_e   ex_alu_op;
	opb_src_e  ex_opb_src;
	word_t     ex_imm, ex_pc, ex_rs_val, ex_rt_val;
	reg_addr_t ex_rs, ex_rt;
	logic      ex_reg_we, ex_store;
	fwd_src_e  fwd_a, fwd_b;
	word_t     op_a, rt_val, op_b, alu_y;

	// memory stage is younger, so it wins over writeback
	function automatic fwd_src_e fwd_select(input reg_addr_t r);
		if (r != '0 && mem_we && mem_rw == r)
			return FWD_MEM;
		if (r != '0 && wb_we && wb_rw == r)
			return FWD_WB;
		return FWD_REG;
	endfunction

	function automatic word_t fwd_value(input fwd_src_e src, input word_t reg_val);
		case (src)
			FWD_MEM: return mem_result;
			FWD_WB:  return wb_data;
			default: return reg_val;
		endcase
	endfunction

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ex_reg_we <= 1'b0;
			ex_load   <= 1'b0;
			ex_store  <= 1'b0;
		end else begin
			ex_reg_we <= d_reg_we;
			ex_load   <= d_load;
			ex_store  <= d_store;
		end
	end

	always_ff @(posedge clk) begin
		ex_alu_op  <= d_alu_op;
		ex_opb_src <= d_opb_src;
		ex_imm     <= d_imm;
		ex_rs      <= d_rs;
		ex_rt      <= d_rt;
		ex_rw      <= d_rw;
		ex_pc      <= d_pc;
		ex_rs_val  <= d_rs_val;
		ex_rt_val  <= d_rt_val;
	end

	assign fwd_a  = fwd_select(ex_rs);
	assign fwd_b  = fwd_select(ex_rt);
	assign op_a   = fwd_value(fwd_a, ex_rs_val);
	assign rt_val = fwd_value(fwd_b, ex_rt_val);
	assign op_b   = (ex_opb_src == OPB_IMM) ? ex_imm : rt_val;

	always_comb begin
		case (ex_alu_op)
			ALU_SUB:  alu_y = op_a - op_b;
			ALU_AND:  alu_y = op_a & op_b;
			ALU_OR:   alu_y = op_a | op_b;
			ALU_XOR:  alu_y = op_a ^ op_b;
			ALU_SLT:  alu_y = {{(WORD_W-1){1'b0}}, $signed(op_a) < $signed(op_b)};
			ALU_SLTU: alu_y = {{(WORD_W-1){1'b0}}, op_a < op_b};
			ALU_SLL:  alu_y = op_a << op_b[SHAMT_W-1:0];
			ALU_LUI:  alu_y = {op_b[IMM_W-1:0], {(WORD_W-IMM_W){1'b0}}};
			default:  alu_y = op_a + op_b;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			m_reg_we <= 1'b0;
			m_load   <= 1'b0;
			m_store  <= 1'b0;
		end else begin
			m_reg_we <= ex_reg_we;
			m_load   <= ex_load;
			m_store  <= ex_store;
		end
	end

	always_ff @(posedge clk) begin
		m_result     <= alu_y;
		m_store_data <= rt_val;
		m_rw         <= ex_rw;
		m_pc         <= ex_pc;
	end

endmodule

/* memory/mem_wb_stage.sv */
module mem_wb_stage
	import mips_isa_pkg::*;
	import pipe_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  word_t      m_result,
	input  word_t      m_store_data,
	input  reg_addr_t  m_rw,
	input  logic       m_reg_we,
	input  logic       m_load,
	input  logic       m_store,
	input  word_t      m_pc,
	output logic       data_sram_en,
	output logic [3:0] data_sram_wen,
	output word_t      data_sram_addr,
	output word_t      data_sram_wdata,
	input  word_t      data_sram_rdata,
	output reg_addr_t  mem_rw,
	output logic       mem_we,
	output word_t      mem_result,
	output reg_addr_t  wb_rw,
	output logic       wb_we,
	output word_t      wb_data,
	output word_t      debug_wb_pc
);
	wb_src_e wb_src;
	word_t   wb_alu;

	// whole words only
	assign data_sram_en    = m_load | m_store;
	assign data_sram_wen   = {4{m_store}};
	assign data_sram_addr  = m_result;
	assign data_sram_wdata = m_store_data;

	assign mem_rw     = m_rw;
	assign mem_we     = m_reg_we;
	assign mem_result = m_result;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wb_we  <= 1'b0;
			wb_src <= WB_ALU;
		end else begin
			wb_we  <= m_reg_we;
			wb_src <= m_load ? WB_LOAD : WB_ALU;
		end
	end

	always_ff @(posedge clk) begin
		wb_rw       <= m_rw;
		wb_alu      <= m_result;
		debug_wb_pc <= m_pc;
	end

	// load data arrives from the sram in this cycle
	assign wb_data = (wb_src == WB_LOAD) ? data_sram_rdata : wb_alu;

endmodule

/* src/mycpu_top.sv */
module mycpu_top
	import mips_isa_pkg::*;
#(
	parameter word_t RESET_PC = 32'hbfc00000
) (
	input  logic      clk,
	input  logic      rst_n,
	output logic      inst_sram_en,
	output word_t     inst_sram_addr,
	input  word_t     inst_sram_rdata,
	output logic      data_sram_en,
	output logic [3:0] data_sram_wen,
	output word_t     data_sram_addr,
	output word_t     data_sram_wdata,
	input  word_t     data_sram_rdata,
	output word_t     debug_wb_pc,
	output logic [3:0] debug_wb_rf_wen,
	output reg_addr_t debug_wb_rf_wnum,
	output word_t     debug_wb_rf_wdata
);
	word_t     id_pc, id_inst;
	logic      stall;
	reg_addr_t rs_addr, rt_addr;
	word_t     rs_data, rt_data;

	pipe_pkg::alu_op_e  d_alu_op;
	pipe_pkg::opb_src_e d_opb_src;
	word_t     d_imm, d_pc, d_rs_val, d_rt_val;
	reg_addr_t d_rs, d_rt, d_rw;
	logic      d_reg_we, d_load, d_store;

	reg_addr_t ex_rw;
	logic      ex_load;

	word_t     m_result, m_store_data, m_pc;
	reg_addr_t m_rw;
	logic      m_reg_we, m_load, m_store;

	reg_addr_t mem_rw, wb_rw;
	logic      mem_we, wb_we;
	word_t     mem_result, wb_data;

	fetch_stage #(.RESET_PC(RESET_PC)) u_fetch (
		.clk(clk), .rst_n(rst_n), .stall(stall),
		.fetch_addr(inst_sram_addr), .fetch_en(inst_sram_en),
		.inst_rdata(inst_sram_rdata), .id_pc(id_pc), .id_inst(id_inst)
	);

	decode_stage u_decode (
		.clk(clk), .rst_n(rst_n), .id_inst(id_inst), .id_pc(id_pc),
		.rs_data(rs_data), .rt_data(rt_data), .ex_rw(ex_rw), .ex_load(ex_load),
		.rs_addr(rs_addr), .rt_addr(rt_addr), .stall(stall),
		.d_alu_op(d_alu_op), .d_opb_src(d_opb_src), .d_imm(d_imm),
		.d_rs(d_rs), .d_rt(d_rt), .d_rw(d_rw), .d_reg_we(d_reg_we),
		.d_load(d_load), .d_store(d_store), .d_pc(d_pc),
		.d_rs_val(d_rs_val), .d_rt_val(d_rt_val)
	);

	reg_file u_regs (
		.clk(clk), .rst_n(rst_n),
		.raddr1(rs_addr), .raddr2(rt_addr), .rdata1(rs_data), .rdata2(rt_data),
		.we(wb_we), .waddr(wb_rw), .wdata(wb_data)
	);

	execute_stage u_execute (
		.clk(clk), .rst_n(rst_n),
		.d_alu_op(d_alu_op), .d_opb_src(d_opb_src), .d_imm(d_imm),
		.d_rs(d_rs), .d_rt(d_rt), .d_rw(d_rw), .d_reg_we(d_reg_we),
		.d_load(d_load), .d_store(d_store), .d_pc(d_pc),
		.d_rs_val(d_rs_val), .d_rt_val(d_rt_val),
		.mem_rw(mem_rw), .mem_we(mem_we), .mem_result(mem_result),
		.wb_rw(wb_rw), .wb_we(wb_we), .wb_data(wb_data),
		.ex_rw(ex_rw), .ex_load(ex_load),
		.m_result(m_result), .m_store_data(m_store_data), .m_rw(m_rw),
		.m_reg_we(m_reg_we), .m_load(m_load), .m_store(m_store), .m_pc(m_pc)
	);

	mem_wb_stage u_mem_wb (
		.clk(clk), .rst_n(rst_n),
		.m_result(m_result), .m_store_data(m_store_data), .m_rw(m_rw),
		.m_reg_we(m_reg_we), .m_load(m_load), .m_store(m_store), .m_pc(m_pc),
		.data_sram_en(data_sram_en), .data_sram_wen(data_sram_wen),
		.data_sram_addr(data_sram_addr), .data_sram_wdata(data_sram_wdata),
		.data_sram_rdata(data_sram_rdata),
		.mem_rw(mem_rw), .mem_we(mem_we), .mem_result(mem_result),
		.wb_rw(wb_rw), .wb_we(wb_we), .wb_data(wb_data), .debug_wb_pc(debug_wb_pc)
	);

	// trace mirrors the register file write port
	assign debug_wb_rf_wen   = {4{wb_we}};
	assign debug_wb_rf_wnum  = wb_rw;
	assign debug_wb_rf_wdata = wb_data;

endmodule

/* tests/mycpu_checker.sv */
module mycpu_checker (
	input logic       clk,
	input logic       rst_n,
	input logic [3:0] debug_wb_rf_wen,
	input logic [4:0] debug_wb_rf_wnum,
	input logic       data_sram_en,
	input logic [3:0] data_sram_wen
);
	timeunit 1ns;
	timeprecision 1ps;

	trace_wen_uniform: assert property (@(posedge clk) disable iff (!rst_n)
		debug_wb_rf_wen == 4'b0000 || debug_wb_rf_wen == 4'b1111)
		else $error("trace enable bits differ: %b", debug_wb_rf_wen);

	// pipeline is still empty in the cycle after each reset edge
	quiet_in_reset: assert property (@(posedge clk)
		!rst_n |=> debug_wb_rf_wen == 4'b0000 && data_sram_wen == 4'b0000 && !data_sram_en)
		else $error("trace or data write during reset");

	no_r0_trace: assert property (@(posedge clk) disable iff (!rst_n)
		debug_wb_rf_wen != 4'b0000 |-> debug_wb_rf_wnum != 5'd0)
		else $error("trace write names register 0");

	wen_needs_en: assert property (@(posedge clk) disable iff (!rst_n)
		data_sram_wen != 4'b0000 |-> data_sram_en)
		else $error("data_sram_wen set without data_sram_en");

endmodule

bind mycpu_top mycpu_checker u_checker (
	.clk(clk),
	.rst_n(rst_n),
	.debug_wb_rf_wen(debug_wb_rf_wen),
	.debug_wb_rf_wnum(debug_wb_rf_wnum),
	.data_sram_en(data_sram_en),
	.data_sram_wen(data_sram_wen)
);

/* tests/tb_mycpu.sv */
module tb_mycpu;
	timeunit 1ns;
	timeprecision 1ps;

	localparam logic [31:0] RESET_PC = 32'hbfc00000;

	localparam logic [5:0] OP_ADDIU = 6'h09;
	localparam logic [5:0] OP_ORI   = 6'h0d;
	localparam logic [5:0] OP_LUI   = 6'h0f;
	localparam logic [5:0] OP_LW    = 6'h23;
	localparam logic [5:0] OP_SW    = 6'h2b;
	localparam logic [5:0] F_SLL    = 6'h00;
	localparam logic [5:0] F_ADDU   = 6'h21;
	localparam logic [5:0] F_SUBU   = 6'h23;
	localparam logic [5:0] F_AND    = 6'h24;
	localparam logic [5:0] F_OR     = 6'h25;
	localparam logic [5:0] F_XOR    = 6'h26;
	localparam logic [5:0] F_SLT    = 6'h2a;
	localparam logic [5:0] F_SLTU   = 6'h2b;

	logic        clk;
	logic        rst_n;
	logic        inst_sram_en;
	logic [31:0] inst_sram_addr;
	logic [31:0] inst_sram_rdata;
	logic        data_sram_en;
	logic [3:0]  data_sram_wen;
	logic [31:0] data_sram_addr;
	logic [31:0] data_sram_wdata;
	logic [31:0] data_sram_rdata;
	logic [31:0] debug_wb_pc;
	logic [3:0]  debug_wb_rf_wen;
	logic [4:0]  debug_wb_rf_wnum;
	logic [31:0] debug_wb_rf_wdata;

	// program rows: instruction, target register (0 for none), value
	logic [31:0] prog_inst[$];
	logic [4:0]  row_rw[$];
	logic [31:0] row_data[$];
	logic [31:0] exp_pc[$];
	logic [4:0]  exp_rw[$];
	logic [31:0] exp_data[$];
	logic [31:0] exp_st_addr[$];
	logic [31:0] exp_st_data[$];
	logic [31:0] dmem [logic [31:0]];

	int   errors = 0;
	int   other_errors = 0;
	int   cycles = 0;
	int   max_cycles = 0;
	int   trace_idx = 0;
	int   st_idx = 0;
	logic fetch_seen = 1'b0;

	mycpu_top #(.RESET_PC(RESET_PC)) dut (
		.clk(clk), .rst_n(rst_n),
		.inst_sram_en(inst_sram_en), .inst_sram_addr(inst_sram_addr),
		.inst_sram_rdata(inst_sram_rdata),
		.data_sram_en(data_sram_en), .data_sram_wen(data_sram_wen),
		.data_sram_addr(data_sram_addr), .data_sram_wdata(data_sram_wdata),
		.data_sram_rdata(data_sram_rdata),
		.debug_wb_pc(debug_wb_pc), .debug_wb_rf_wen(debug_wb_rf_wen),
		.debug_wb_rf_wnum(debug_wb_rf_wnum), .debug_wb_rf_wdata(debug_wb_rf_wdata)
	);

	function automatic logic [31:0] r_type(input logic [5:0] funct, input int rs,
		input int rt, input int rd, input int sh);
		return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'(sh), funct};
	endfunction

	function automatic logic [31:0] i_type(input logic [5:0] op, input int rs,
		input int rt, input logic [15:0] imm);
		return {op, 5'(rs), 5'(rt), imm};
	endfunction

	function automatic logic [31:0] fetch_word(input logic [31:0] addr);
		int slot;
		slot = int'((addr - RESET_PC) >> 2);
		if (slot < prog_inst.size())
			return prog_inst[slot];
		return 32'h0;
	endfunction

	// untouched words read back a pattern of their address
	function automatic logic [31:0] read_word(input logic [31:0] addr);
		if (dmem.exists(addr))
			return dmem[addr];
		return {addr[15:0], addr[31:16]} ^ 32'h5a5aa5a5;
	endfunction

	task automatic add_row(input logic [31:0] inst, input int rw, input logic [31:0] data);
		prog_inst.push_back(inst);
		row_rw.push_back(5'(rw));
		row_data.push_back(data);
	endtask

	task automatic add_store(input logic [31:0] addr, input logic [31:0] data);
		exp_st_addr.push_back(addr);
		exp_st_data.push_back(data);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("** Error: %s is %h, expected %h", name, got, exp);
		end
	endtask

	task automatic build_program();
		add_row(i_type(OP_LUI, 0, 1, 16'h8000), 1, 32'h80000000);
		add_row(i_type(OP_ORI, 0, 2, 16'hffff), 2, 32'h0000ffff);
		add_row(i_type(OP_ADDIU, 0, 3, 16'hffff), 3, 32'hffffffff);
		add_row(i_type(OP_ADDIU, 0, 4, 16'h0005), 4, 32'h00000005);
		// producers at distance 1, 2 and 3
		add_row(r_type(F_ADDU, 4, 2, 5, 0), 5, 32'h00010004);
		add_row(r_type(F_SUBU, 5, 4, 6, 0), 6, 32'h0000ffff);
		add_row(r_type(F_AND, 3, 5, 7, 0), 7, 32'h00010004);
		add_row(r_type(F_OR, 1, 4, 8, 0), 8, 32'h80000005);
		add_row(r_type(F_XOR, 3, 2, 9, 0), 9, 32'hffff0000);
		add_row(r_type(F_SLT, 1, 4, 10, 0), 10, 32'h00000001);
		add_row(r_type(F_SLTU, 1, 4, 11, 0), 11, 32'h00000000);
		add_row(r_type(F_SLT, 4, 1, 21, 0), 21, 32'h00000000);
		add_row(r_type(F_SLTU, 4, 1, 22, 0), 22, 32'h00000001);
		add_row(r_type(F_SLL, 0, 4, 12, 3), 12, 32'h00000028);
		// r0 target stays off the trace
		add_row(i_type(OP_ADDIU, 4, 0, 16'h0007), 0, 32'h0);
		add_row(r_type(F_ADDU, 0, 4, 13, 0), 13, 32'h00000005);
		add_row(i_type(OP_ADDIU, 0, 14, 16'h0100), 14, 32'h00000100);
		add_row(i_type(OP_LUI, 0, 15, 16'h1234), 15, 32'h12340000);
		add_row(i_type(OP_ORI, 15, 15, 16'h5678), 15, 32'h12345678);
		add_row(i_type(OP_SW, 14, 15, 16'h0004), 0, 32'h0);
		add_store(32'h00000104, 32'h12345678);
		add_row(i_type(OP_SW, 14, 9, 16'h0008), 0, 32'h0);
		add_store(32'h00000108, 32'hffff0000);
		// load-use pairs
		add_row(i_type(OP_LW, 14, 16, 16'h0004), 16, 32'h12345678);
		add_row(r_type(F_ADDU, 16, 4, 17, 0), 17, 32'h1234567d);
		add_row(i_type(OP_LW, 14, 18, 16'h0008), 18, 32'hffff0000);
		add_row(r_type(F_SLL, 0, 18, 19, 4), 19, 32'hfff00000);
		add_row(i_type(OP_ADDIU, 17, 20, 16'hfffe), 20, 32'h1234567b);
		for (int i = 0; i < prog_inst.size(); i++) begin
			if (row_rw[i] != 5'd0) begin
				exp_pc.push_back(RESET_PC + 32'(4 * i));
				exp_rw.push_back(row_rw[i]);
				exp_data.push_back(row_data[i]);
			end
		end
		max_cycles = 2 * prog_inst.size() + 20;
	endtask

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// instruction and data SRAM, one cycle read latency
	always @(posedge clk) begin
		if (inst_sram_en)
			inst_sram_rdata <= fetch_word(inst_sram_addr);
		if (data_sram_en) begin
			data_sram_rdata <= read_word(data_sram_addr);
			if (data_sram_wen == 4'b1111)
				dmem[data_sram_addr] = data_sram_wdata;
		end
	end

	always @(negedge clk) begin
		cycles++;
		if (!rst_n) begin
			check_value("debug_wb_rf_wen", 32'(debug_wb_rf_wen), 32'h0);
			check_value("data_sram_en", 32'(data_sram_en), 32'h0);
			check_value("data_sram_wen", 32'(data_sram_wen), 32'h0);
			check_value("inst_sram_en", 32'(inst_sram_en), 32'h0);
		end else begin
			if (!fetch_seen) begin
				check_value("inst_sram_en", 32'(inst_sram_en), 32'h1);
				check_value("inst_sram_addr", inst_sram_addr, RESET_PC);
				fetch_seen = 1'b1;
			end
			if (debug_wb_rf_wen != 4'h0) begin
				if (trace_idx < exp_pc.size()) begin
					check_value("debug_wb_pc", debug_wb_pc, exp_pc[trace_idx]);
					check_value("debug_wb_rf_wnum", 32'(debug_wb_rf_wnum),
						32'(exp_rw[trace_idx]));
					check_value("debug_wb_rf_wdata", debug_wb_rf_wdata, exp_data[trace_idx]);
					trace_idx++;
				end else begin
					other_errors++;
					$display("unexpected register write to r%0d from pc %h",
						debug_wb_rf_wnum, debug_wb_pc);
				end
			end
			if (data_sram_wen != 4'h0) begin
				if (st_idx < exp_st_addr.size()) begin
					check_value("data_sram_wen", 32'(data_sram_wen), 32'hf);
					check_value("data_sram_addr", data_sram_addr, exp_st_addr[st_idx]);
					check_value("data_sram_wdata", data_sram_wdata, exp_st_data[st_idx]);
					st_idx++;
				end else begin
					other_errors++;
					$display("unexpected store to address %h", data_sram_addr);
				end
			end
		end
	end

	initial begin
		rst_n = 1'b0;
		inst_sram_rdata = 32'h0;
		data_sram_rdata = 32'h0;
		build_program();
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		while (trace_idx < exp_pc.size() && cycles < max_cycles)
			@(posedge clk);
		if (trace_idx < exp_pc.size()) begin
			other_errors++;
			$display("timeout after %0d cycles, %0d of %0d register writes never arrived",
				cycles, exp_pc.size() - trace_idx, exp_pc.size());
		end else begin
			// a few more cycles to catch stray writes
			repeat (5) @(posedge clk);
		end
		if (st_idx != exp_st_addr.size()) begin
			other_errors++;
			$display("only %0d of %0d stores reached the data SRAM", st_idx,
				exp_st_addr.size());
		end
		$display("errors: %0d value mismatches, %0d other failures", errors, other_errors);
		if (errors == 0 && other_errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

/* project.f */
common/mips_isa_pkg.sv
common/pipe_pkg.sv
fetch/fetch_stage.sv
decode/reg_file.sv
decode/decode_stage.sv
execute/execute_stage.sv
memory/mem_wb_stage.sv
src/mycpu_top.sv
tests/mycpu_checker.sv
tests/tb_mycpu.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" \
	&& verilator --binary --timing --assert -f project.f --top-module tb_mycpu -o tb_mycpu \
	&& ./obj_dir/tb_mycpu | tee /dev/stderr | grep -q "Simulation passed" \
	&& echo "run_sim: PASS" \
	|| { echo "run_sim: FAIL"; exit 1; }
